/* src/hpcp_pkg.sv */
package hpcp_pkg;

  //============================================================
  // Widths
  //============================================================

  // Event selector register width
  localparam int HPMEVT_WIDTH = 6;

  // Register bus data and address
  localparam int DATA_W = 64;
  localparam int ADDR_W = 8;

  //============================================================
  // Register address map
  //============================================================

  // Shared inhibit register, one bit per counter
  localparam logic [ADDR_W-1:0] ADDR_INHIBIT = 8'h00;

  // Counter i at ADDR_CNT_BASE + i
  localparam logic [ADDR_W-1:0] ADDR_CNT_BASE = 8'h10;

  // Selector i at ADDR_SEL_BASE + i
  localparam logic [ADDR_W-1:0] ADDR_SEL_BASE = 8'h20;

  //============================================================
  // Bus ownership
  //============================================================

  // Who drives the register bus in a given cycle
  typedef enum logic [1:0] {
    OWN_NONE = 2'd0,
    OWN_CORE = 2'd1,
    OWN_DBG  = 2'd2
  } hpcp_owner_e;

endpackage

/* src/hpcp_event_sel.sv */
`timescale 1ns/1ps

module hpcp_event_sel
  import hpcp_pkg::*;
#(
  parameter int EVT_NUM = 42
) (
  input  logic                    eventx_clk,
  input  logic                    cpurst_b,
  input  logic                    wen,
  input  logic [DATA_W-1:0]       wdata,
  input  logic [EVT_NUM-1:0]      events,
  output logic [HPMEVT_WIDTH-1:0] sel_value,
  output logic                    evt_hit
);

  logic                    value_ok;
  logic [HPMEVT_WIDTH-1:0] sel_q;
  // Slot 0 is the "no event" code
  logic [EVT_NUM:0]        evt_ext;

  //============================================================
  // Legal-value mask on write
  //============================================================

  // Upper bits must be clear
  // Low bits must name an existing event
  assign value_ok = !(|wdata[DATA_W-1:HPMEVT_WIDTH])
                 && (wdata[HPMEVT_WIDTH-1:0] <= HPMEVT_WIDTH'(EVT_NUM));

  always_ff @(posedge eventx_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      sel_q <= '0;
    else if (wen)
      sel_q <= wdata[HPMEVT_WIDTH-1:0] & {HPMEVT_WIDTH{value_ok}};
  end

  //============================================================
  // Event pick
  //============================================================

  // Selector k maps to event bit k-1
  assign evt_ext = {events, 1'b0};

  // sel_q never exceeds EVT_NUM so the index stays in range
  assign evt_hit = evt_ext[sel_q];

  assign sel_value = sel_q;

endmodule

/* src/hpcp_counter.sv */
`timescale 1ns/1ps

module hpcp_counter
  import hpcp_pkg::*;
#(
  parameter int EVT_NUM = 42
) (
  input  logic                    eventx_clk,
  input  logic                    cpurst_b,
  input  logic                    cnt_wen,
  input  logic                    sel_wen,
  input  logic [DATA_W-1:0]       wdata,
  input  logic [EVT_NUM-1:0]      events,
  input  logic                    inhibit,
  output logic [DATA_W-1:0]       cnt_value,
  output logic [HPMEVT_WIDTH-1:0] sel_value
);

  logic              evt_hit;
  logic              cnt_inc;
  logic [DATA_W-1:0] cnt_q;

  //============================================================
  // Own event selector
  //============================================================

  hpcp_event_sel #(
    .EVT_NUM (EVT_NUM)
  ) x_event_sel (
    .eventx_clk (eventx_clk),
    .cpurst_b   (cpurst_b),
    .wen        (sel_wen),
    .wdata      (wdata),
    .events     (events),
    .sel_value  (sel_value),
    .evt_hit    (evt_hit)
  );

  //============================================================
  // Counter register
  //============================================================

  // Clock enable in place of a gated clock
  assign cnt_inc = evt_hit && !inhibit;

  // Preload beats increment
  // Natural wrap at 2^64
  always_ff @(posedge eventx_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cnt_q <= '0;
    else if (cnt_wen)
      cnt_q <= wdata;
    else if (cnt_inc)
      cnt_q <= cnt_q + 1'b1;
  end

  assign cnt_value = cnt_q;

endmodule

/* src/hpcp_bus_arb.sv */
`timescale 1ns/1ps

module hpcp_bus_arb
  import hpcp_pkg::*;
(
  input  logic              eventx_clk,
  input  logic              cpurst_b,
  // Core CSR port
  input  logic              core_req,
  input  logic              core_wen,
  input  logic [ADDR_W-1:0] core_addr,
  input  logic [DATA_W-1:0] core_wdata,
  output logic [DATA_W-1:0] core_rdata,
  output logic              core_done,
  // Debug port
  input  logic              dbg_req,
  input  logic              dbg_wen,
  input  logic [ADDR_W-1:0] dbg_addr,
  input  logic [DATA_W-1:0] dbg_wdata,
  output logic [DATA_W-1:0] dbg_rdata,
  output logic              dbg_done,
  // Register bus
  output logic              bus_sel,
  output logic              bus_wen,
  output logic [ADDR_W-1:0] bus_addr,
  output logic [DATA_W-1:0] bus_wdata,
  input  logic [DATA_W-1:0] bus_rdata
);

  hpcp_owner_e owner;
  hpcp_owner_e last_owner;

  //============================================================
  // Owner pick
  //============================================================

  // Core first, then debug
  // A port showing done this cycle is skipped
  always_comb
  begin
    if (core_req && !core_done)
      owner = OWN_CORE;
    else if (dbg_req && !dbg_done)
      owner = OWN_DBG;
    else
      owner = OWN_NONE;
  end

  // Steer winner onto the bus
  always_comb
  begin
    case (owner)
      OWN_CORE:
      begin
        bus_wen   = core_wen;
        bus_addr  = core_addr;
        bus_wdata = core_wdata;
      end
      OWN_DBG:
      begin
        bus_wen   = dbg_wen;
        bus_addr  = dbg_addr;
        bus_wdata = dbg_wdata;
      end
      default:
      begin
        bus_wen   = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
      end
    endcase
  end

  assign bus_sel = (owner != OWN_NONE);

  //============================================================
  // Done and read data return
  //============================================================

  always_ff @(posedge eventx_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      last_owner <= OWN_NONE;
    else
      last_owner <= owner;
  end

  // One-cycle pulse to last cycle's owner
  assign core_done = (last_owner == OWN_CORE);
  assign dbg_done  = (last_owner == OWN_DBG);

  // Read data held until the next access of the same port
  always_ff @(posedge eventx_clk)
  begin
    if (owner == OWN_CORE)
      core_rdata <= bus_rdata;
    if (owner == OWN_DBG)
      dbg_rdata <= bus_rdata;
  end

endmodule

/* src/hpcp_regfile.sv */
`timescale 1ns/1ps

module hpcp_regfile
  import hpcp_pkg::*;
#(
  parameter int CNT_NUM = 4,
  parameter int EVT_NUM = 42
) (
  input  logic                                 eventx_clk,
  input  logic                                 cpurst_b,
  // Register bus
  input  logic                                 bus_sel,
  input  logic                                 bus_wen,
  input  logic [ADDR_W-1:0]                    bus_addr,
  input  logic [DATA_W-1:0]                    bus_wdata,
  output logic [DATA_W-1:0]                    bus_rdata,
  // Counter side
  output logic [CNT_NUM-1:0]                   cnt_wen,
  output logic [CNT_NUM-1:0]                   sel_wen,
  output logic [DATA_W-1:0]                    wdata,
  output logic [CNT_NUM-1:0]                   inhibit,
  input  logic [CNT_NUM-1:0][DATA_W-1:0]       cnt_values,
  input  logic [CNT_NUM-1:0][HPMEVT_WIDTH-1:0] sel_values
);

  logic               bus_write;
  logic               inh_hit;
  logic [CNT_NUM-1:0] cnt_hit;
  logic [CNT_NUM-1:0] sel_hit;
  logic [CNT_NUM-1:0] inhibit_q;

  //============================================================
  // Parameter range check
  //============================================================

  // More than 16 counters would overlap the selector block
  // Selector field holds at most 63
  if ((CNT_NUM < 1) || (CNT_NUM > 16) || (EVT_NUM < 1) || (EVT_NUM > 63))
  begin : g_param_check
    $error("hpcp_regfile: CNT_NUM or EVT_NUM out of range");
  end

  //============================================================
  // Address decode
  //============================================================

  assign bus_write = bus_sel && bus_wen;
  assign inh_hit   = (bus_addr == ADDR_INHIBIT);

  // One hit bit per counter and per selector
  always_comb
  begin
    for (int i = 0; i < CNT_NUM; i++)
    begin
      cnt_hit[i] = (bus_addr == ADDR_W'(ADDR_CNT_BASE + i));
      sel_hit[i] = (bus_addr == ADDR_W'(ADDR_SEL_BASE + i));
    end
  end

  // Write strobes, one-hot
  // Unmapped addresses raise nothing
  assign cnt_wen = cnt_hit & {CNT_NUM{bus_write}};
  assign sel_wen = sel_hit & {CNT_NUM{bus_write}};

  // Shared write data to every counter
  assign wdata = bus_wdata;

  //============================================================
  // Inhibit register
  //============================================================

  // Only the low CNT_NUM bits are kept
  always_ff @(posedge eventx_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      inhibit_q <= '0;
    else if (bus_write && inh_hit)
      inhibit_q <= bus_wdata[CNT_NUM-1:0];
  end

  assign inhibit = inhibit_q;

  //============================================================
  // Read data mux
  //============================================================

  // Zero for any unmapped address
  // Narrow registers zero-extended to the bus
  always_comb
  begin
    bus_rdata = '0;
    if (inh_hit)
      bus_rdata = {{(DATA_W-CNT_NUM){1'b0}}, inhibit_q};
    for (int i = 0; i < CNT_NUM; i++)
    begin
      if (cnt_hit[i])
        bus_rdata = cnt_values[i];
      if (sel_hit[i])
        bus_rdata = {{(DATA_W-HPMEVT_WIDTH){1'b0}}, sel_values[i]};
    end
  end

endmodule

/* src/hpcp_top.sv */
`timescale 1ns/1ps

module hpcp_top
  import hpcp_pkg::*;
#(
  parameter int CNT_NUM = 4,
  parameter int EVT_NUM = 42
) (
  input  logic               eventx_clk,
  input  logic               cpurst_b,
  // Core CSR port
  input  logic               core_req,
  input  logic               core_wen,
  input  logic [ADDR_W-1:0]  core_addr,
  input  logic [DATA_W-1:0]  core_wdata,
  output logic [DATA_W-1:0]  core_rdata,
  output logic               core_done,
  // Debug port
  input  logic               dbg_req,
  input  logic               dbg_wen,
  input  logic [ADDR_W-1:0]  dbg_addr,
  input  logic [DATA_W-1:0]  dbg_wdata,
  output logic [DATA_W-1:0]  dbg_rdata,
  output logic               dbg_done,
  // Event inputs
  input  logic [EVT_NUM-1:0] events
);

  // Register bus
  logic              bus_sel;
  logic              bus_wen;
  logic [ADDR_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_wdata;
  logic [DATA_W-1:0] bus_rdata;

  // Per-counter strobes and state
  logic [CNT_NUM-1:0]                   cnt_wen;
  logic [CNT_NUM-1:0]                   sel_wen;
  logic [DATA_W-1:0]                    wdata;
  logic [CNT_NUM-1:0]                   inhibit;
  logic [CNT_NUM-1:0][DATA_W-1:0]       cnt_values;
  logic [CNT_NUM-1:0][HPMEVT_WIDTH-1:0] sel_values;

  //============================================================
  // Port arbiter
  //============================================================

  hpcp_bus_arb x_bus_arb (
    .eventx_clk (eventx_clk),
    .cpurst_b   (cpurst_b),
    .core_req   (core_req),
    .core_wen   (core_wen),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_rdata (core_rdata),
    .core_done  (core_done),
    .dbg_req    (dbg_req),
    .dbg_wen    (dbg_wen),
    .dbg_addr   (dbg_addr),
    .dbg_wdata  (dbg_wdata),
    .dbg_rdata  (dbg_rdata),
    .dbg_done   (dbg_done),
    .bus_sel    (bus_sel),
    .bus_wen    (bus_wen),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata)
  );

  //============================================================
  // Register file
  //============================================================

  hpcp_regfile #(
    .CNT_NUM (CNT_NUM),
    .EVT_NUM (EVT_NUM)
  ) x_regfile (
    .eventx_clk (eventx_clk),
    .cpurst_b   (cpurst_b),
    .bus_sel    (bus_sel),
    .bus_wen    (bus_wen),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata),
    .cnt_wen    (cnt_wen),
    .sel_wen    (sel_wen),
    .wdata      (wdata),
    .inhibit    (inhibit),
    .cnt_values (cnt_values),
    .sel_values (sel_values)
  );

  //============================================================
  // Event counters
  //============================================================

  for (genvar i = 0; i < CNT_NUM; i++)
  begin : g_cnt
    hpcp_counter #(
      .EVT_NUM (EVT_NUM)
    ) x_counter (
      .eventx_clk (eventx_clk),
      .cpurst_b   (cpurst_b),
      .cnt_wen    (cnt_wen[i]),
      .sel_wen    (sel_wen[i]),
      .wdata      (wdata),
      .events     (events),
      .inhibit    (inhibit[i]),
      .cnt_value  (cnt_values[i]),
      .sel_value  (sel_values[i])
    );
  end

endmodule

/* tests/hpcp_clkgen.sv */
`timescale 1ns/1ps

module hpcp_clkgen (
  output logic eventx_clk,
  output logic cpurst_b
);

  // 8 ns period
  initial
  begin
    eventx_clk = 1'b0;
    forever #4 eventx_clk = ~eventx_clk;
  end

  // Reset held low for 16 rising edges
  initial
  begin
    cpurst_b = 1'b0;
    repeat (16) @(posedge eventx_clk);
    cpurst_b <= 1'b1;
  end

endmodule

/* tests/hpcp_top_assert.sv */
`timescale 1ns/1ps

module hpcp_top_assert (
  input logic eventx_clk,
  input logic cpurst_b,
  input logic core_req,
  input logic core_done,
  input logic dbg_req,
  input logic dbg_done
);

  // Only one port finishes per cycle
  a_done_excl: assert property (@(posedge eventx_clk) disable iff (!cpurst_b)
    !(core_done && dbg_done))
    else $error("core_done and dbg_done high together");

  // Done only for a request held over two edges
  a_core_done: assert property (@(posedge eventx_clk) disable iff (!cpurst_b)
    core_done |-> core_req && $past(core_req))
    else $error("core_done without a held core_req");

  a_dbg_done: assert property (@(posedge eventx_clk) disable iff (!cpurst_b)
    dbg_done |-> dbg_req && $past(dbg_req))
    else $error("dbg_done without a held dbg_req");

  // Quiet ports during reset
  a_reset_quiet: assert property (@(posedge eventx_clk)
    !cpurst_b |-> !core_done && !dbg_done)
    else $error("done high during reset");

endmodule

bind hpcp_top hpcp_top_assert x_top_assert (
  .eventx_clk (eventx_clk),
  .cpurst_b   (cpurst_b),
  .core_req   (core_req),
  .core_done  (core_done),
  .dbg_req    (dbg_req),
  .dbg_done   (dbg_done)
);

/* tests/hpcp_tb.sv */
`timescale 1ns/1ps

module hpcp_tb
  import hpcp_pkg::*;
();

  localparam int CNT_NUM = 4;
  localparam int EVT_NUM = 42;
  localparam int TIMEOUT = 40;

  logic               eventx_clk;
  logic               cpurst_b;
  logic               core_req;
  logic               core_wen;
  logic [ADDR_W-1:0]  core_addr;
  logic [DATA_W-1:0]  core_wdata;
  logic [DATA_W-1:0]  core_rdata;
  logic               core_done;
  logic               dbg_req;
  logic               dbg_wen;
  logic [ADDR_W-1:0]  dbg_addr;
  logic [DATA_W-1:0]  dbg_wdata;
  logic [DATA_W-1:0]  dbg_rdata;
  logic               dbg_done;
  logic [EVT_NUM-1:0] events;

  // Reference model state
  logic [63:0]        model_cnt [CNT_NUM];
  logic [5:0]         model_sel [CNT_NUM];
  logic [CNT_NUM-1:0] model_inh;
  logic [15:0]        lfsr_state;
  logic [63:0]        edge_vals [5];

  hpcp_clkgen x_clkgen (
    .eventx_clk (eventx_clk),
    .cpurst_b   (cpurst_b)
  );

  hpcp_top DUT (.*);

  //============================================================
  // Helpers and reference model
  //============================================================

  // Fibonacci LFSR on taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One step per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Expected selector after a write
  // Anything illegal lands as zero
  function automatic logic [63:0] expect_sel(input logic [63:0] w);
    if ((w[63:6] == '0) && (w[5:0] <= 6'(EVT_NUM)))
      return {58'd0, w[5:0]};
    return 64'd0;
  endfunction

  // Selector k looks at event bit k-1
  // Zero picks nothing
  function automatic logic event_hit(input logic [EVT_NUM-1:0] evts, input logic [5:0] sel);
    logic [63:0] wide;
    wide = '0;
    wide[EVT_NUM:1] = evts;
    return wide[sel];
  endfunction

  function automatic logic [ADDR_W-1:0] cnt_addr(input int i);
    return ADDR_W'(ADDR_CNT_BASE + i);
  endfunction

  function automatic logic [ADDR_W-1:0] sel_addr(input int i);
    return ADDR_W'(ADDR_SEL_BASE + i);
  endfunction

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp)
    begin
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  //============================================================
  // Port access
  //============================================================

  task automatic core_access(input logic wr, input logic [ADDR_W-1:0] addr,
                             input logic [63:0] data, output logic [63:0] rd);
    bit seen;
    seen = 1'b0;
    @(posedge eventx_clk);
    core_req   <= 1'b1;
    core_wen   <= wr;
    core_addr  <= addr;
    core_wdata <= data;
    // Sample done away from the edge
    for (int n = 0; n < TIMEOUT && !seen; n++)
    begin
      @(negedge eventx_clk);
      seen = core_done;
    end
    if (!seen)
    begin
      $display("ERROR at %0t: no done from core port", $time);
      stop_run();
    end
    rd = core_rdata;
    @(posedge eventx_clk);
    core_req <= 1'b0;
    core_wen <= 1'b0;
  endtask

  task automatic dbg_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [63:0] data, output logic [63:0] rd);
    bit seen;
    seen = 1'b0;
    @(posedge eventx_clk);
    dbg_req   <= 1'b1;
    dbg_wen   <= wr;
    dbg_addr  <= addr;
    dbg_wdata <= data;
    for (int n = 0; n < TIMEOUT && !seen; n++)
    begin
      @(negedge eventx_clk);
      seen = dbg_done;
    end
    if (!seen)
    begin
      $display("ERROR at %0t: no done from debug port", $time);
      stop_run();
    end
    rd = dbg_rdata;
    @(posedge eventx_clk);
    dbg_req <= 1'b0;
    dbg_wen <= 1'b0;
  endtask

  // Port 0 is core and port 1 is debug
  task automatic write_reg(input bit port, input logic [ADDR_W-1:0] addr, input logic [63:0] data);
    logic [63:0] rd;
    if (port)
      dbg_access(1'b1, addr, data, rd);
    else
      core_access(1'b1, addr, data, rd);
  endtask

  task automatic read_check(input bit port, input logic [ADDR_W-1:0] addr,
                            input logic [63:0] exp, input string name);
    logic [63:0] rd;
    if (port)
      dbg_access(1'b0, addr, 64'd0, rd);
    else
      core_access(1'b0, addr, 64'd0, rd);
    check_value(name, exp, rd);
  endtask

  // Pattern held one cycle and counted at the next edge
  task automatic drive_events(input logic [EVT_NUM-1:0] pat);
    @(posedge eventx_clk);
    events <= pat;
    for (int i = 0; i < CNT_NUM; i++)
      if (!model_inh[i] && event_hit(pat, model_sel[i]))
        model_cnt[i] = model_cnt[i] + 64'd1;
  endtask

  task automatic random_burst(input int cycles);
    logic [63:0] pat;
    for (int c = 0; c < cycles; c++)
    begin
      pat = take_bits(EVT_NUM);
      drive_events(pat[EVT_NUM-1:0]);
    end
    drive_events('0);
  endtask

  task automatic check_counters();
    for (int i = 0; i < CNT_NUM; i++)
      read_check(i[0], cnt_addr(i), model_cnt[i], $sformatf("counter%0d", i));
  endtask

  //============================================================
  // Stimulus
  //============================================================

  initial
  begin
    logic [63:0] wval;
    logic [63:0] snap [CNT_NUM];
    logic [5:0]  sel;
    bit          core_seen;
    bit          dbg_seen;
    int          core_cyc;
    int          dbg_cyc;

    core_req   = 1'b0;
    core_wen   = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    dbg_req    = 1'b0;
    dbg_wen    = 1'b0;
    dbg_addr   = '0;
    dbg_wdata  = '0;
    events     = '0;
    lfsr_state = 16'd64;
    model_inh  = '0;
    for (int i = 0; i < CNT_NUM; i++)
    begin
      model_cnt[i] = '0;
      model_sel[i] = '0;
    end
    edge_vals = '{64'd0, 64'(EVT_NUM), 64'(EVT_NUM + 1), 64'd63, 64'h1 << 40};

    for (int n = 0; n < 40 && !cpurst_b; n++)
      @(negedge eventx_clk);
    if (!cpurst_b)
    begin
      $display("ERROR at %0t: reset never released", $time);
      stop_run();
    end

    // Everything zero after reset on both ports
    for (int p = 0; p < 2; p++)
    begin
      read_check(p[0], ADDR_INHIBIT, 64'd0, "inhibit");
      for (int i = 0; i < CNT_NUM; i++)
      begin
        read_check(p[0], cnt_addr(i), 64'd0, $sformatf("counter%0d", i));
        read_check(p[0], sel_addr(i), 64'd0, $sformatf("sel%0d", i));
      end
    end

    // Random selector writes
    // Short words hit the legal range more often
    for (int i = 0; i < CNT_NUM; i++)
      for (int k = 0; k < 3; k++)
      begin
        wval = (k == 0) ? take_bits(7) : take_bits(64);
        write_reg(k[0], sel_addr(i), wval);
        read_check(!k[0], sel_addr(i), expect_sel(wval), $sformatf("sel%0d", i));
      end
    // Boundary selector values
    for (int k = 0; k < 5; k++)
    begin
      write_reg(1'b0, sel_addr(k % CNT_NUM), edge_vals[k]);
      read_check(1'b1, sel_addr(k % CNT_NUM), expect_sel(edge_vals[k]),
                 $sformatf("sel%0d", k % CNT_NUM));
    end

    // Legal selectors then a long random event run
    for (int i = 0; i < CNT_NUM; i++)
    begin
      sel = 6'((take_bits(6) % EVT_NUM) + 1);
      write_reg(i[0], sel_addr(i), {58'd0, sel});
      model_sel[i] = sel;
    end
    random_burst(200);
    check_counters();

    // Freeze counters 0 and 2
    // Junk above CNT_NUM is dropped
    wval = 64'hF0F0_0000_0000_0005;
    write_reg(1'b1, ADDR_INHIBIT, wval);
    model_inh = wval[CNT_NUM-1:0];
    read_check(1'b0, ADDR_INHIBIT, 64'(model_inh), "inhibit");
    for (int i = 0; i < CNT_NUM; i++)
      snap[i] = model_cnt[i];
    random_burst(100);
    check_counters();
    for (int i = 0; i < CNT_NUM; i++)
      if (model_inh[i])
        read_check(!i[0], cnt_addr(i), snap[i], $sformatf("inhibited counter%0d", i));
    write_reg(1'b0, ADDR_INHIBIT, 64'd0);
    model_inh = '0;

    // Wrap through 2^64
    write_reg(1'b0, cnt_addr(0), '1);
    model_cnt[0] = '1;
    wval = 64'd1 << (model_sel[0] - 6'd1);
    for (int c = 0; c < 3; c++)
      drive_events(wval[EVT_NUM-1:0]);
    drive_events('0);
    read_check(1'b1, cnt_addr(0), 64'd2, "counter0 wrap");
    check_counters();

    // Unmapped address swallows the write
    write_reg(1'b1, 8'h40, take_bits(64));
    read_check(1'b0, 8'h40, 64'd0, "unmapped");

    // Simultaneous requests
    // Core wins the first slot
    sel = 6'((take_bits(6) % EVT_NUM) + 1);
    wval = take_bits(64);
    core_seen = 1'b0;
    dbg_seen  = 1'b0;
    core_cyc  = 0;
    dbg_cyc   = 0;
    @(posedge eventx_clk);
    core_req   <= 1'b1;
    core_wen   <= 1'b1;
    core_addr  <= sel_addr(1);
    core_wdata <= {58'd0, sel};
    dbg_req    <= 1'b1;
    dbg_wen    <= 1'b1;
    dbg_addr   <= cnt_addr(2);
    dbg_wdata  <= wval;
    for (int c = 1; c <= TIMEOUT && !(core_seen && dbg_seen); c++)
    begin
      @(negedge eventx_clk);
      if (core_done && !core_seen)
      begin
        core_seen = 1'b1;
        core_cyc  = c;
      end
      if (dbg_done && !dbg_seen)
      begin
        dbg_seen = 1'b1;
        dbg_cyc  = c;
      end
      @(posedge eventx_clk);
      if (core_seen)
        core_req <= 1'b0;
      if (dbg_seen)
        dbg_req <= 1'b0;
    end
    if (!core_seen || !dbg_seen)
    begin
      $display("ERROR at %0t: no done from %s port", $time, core_seen ? "debug" : "core");
      stop_run();
    end
    check_value("core_done first", 64'd1, 64'(core_cyc < dbg_cyc));
    model_sel[1] = sel;
    model_cnt[2] = wval;
    read_check(1'b1, sel_addr(1), {58'd0, sel}, "sel1");
    read_check(1'b0, cnt_addr(2), wval, "counter2");

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* hpcp_top.f */
src/hpcp_pkg.sv
src/hpcp_event_sel.sv
src/hpcp_counter.sv
src/hpcp_bus_arb.sv
src/hpcp_regfile.sv
src/hpcp_top.sv
tests/hpcp_clkgen.sv
tests/hpcp_top_assert.sv
tests/hpcp_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module hpcp_tb \
		-f hpcp_top.f --Mdir obj_dir -o hpcp_sim
	./obj_dir/hpcp_sim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
